/* src/image_pkg.sv */
package image_pkg;

    // One 8-bit grayscale sample
    typedef logic [7:0] pixel_t;

    // One row of the neighbourhood, leftmost column first
    typedef struct packed {
        pixel_t c0;
        pixel_t c1;
        pixel_t c2;
        pixel_t c3;
        pixel_t c4;
    } window_row_t;

    // Full 5x5 neighbourhood, top row first
    typedef struct packed {
        window_row_t r0;
        window_row_t r1;
        window_row_t r2;
        window_row_t r3;
        window_row_t r4;
    } window_t;

    // Raster position of the centre pixel
    typedef struct packed {
        logic [15:0] row;
        logic [15:0] col;
    } pixel_pos_t;

endpackage

/* src/blur_pkg.sv */
package blur_pkg;

    // Controller phases: shift in a sample, run the kernel, write the result
    typedef enum logic [1:0] {LOAD, CALC, EMIT} blur_state_t;

    // Weights sum to this, so the quotient never exceeds 255
    localparam int KERNEL_SUM = 159;

    // 255 * 159 = 40545 fits in 16 bits
    localparam int ACC_WIDTH = 16;

    // Kernel is symmetric, so fold both indices to their ring distance from the edge
    function automatic int unsigned kernel_weight(input int unsigned row, input int unsigned col);
        int unsigned ring_r;
        int unsigned ring_c;
        logic [1:0] lo;
        logic [1:0] hi;
        ring_r = (row > 2) ? 4 - row : row;
        ring_c = (col > 2) ? 4 - col : col;
        lo = 2'((ring_r < ring_c) ? ring_r : ring_c);
        hi = 2'((ring_r < ring_c) ? ring_c : ring_r);
        case ({lo, hi})
            4'b0000: return 2;
            4'b0001: return 4;
            4'b0010: return 5;
            4'b0101: return 9;
            4'b0110: return 12;
            4'b1010: return 15;
            default: return 0;
        endcase
    endfunction

endpackage

/* src/pixel_fifo.sv */
`timescale 1ns/1ps

module pixel_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic              clock,
    input  logic              reset,
    input  logic              wr_en,
    input  image_pkg::pixel_t din,
    output logic              full,
    input  logic              rd_en,
    output image_pkg::pixel_t dout,
    output logic              empty
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    image_pkg::pixel_t mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_write;
    logic             do_read;

    // Writes while full and reads while empty are dropped
    assign do_write = wr_en && !full;
    assign do_read  = rd_en && !empty;

    assign full  = (count == CNT_W'(FIFO_DEPTH));
    assign empty = (count == '0);

    // First-word-fall-through: head entry is always visible
    assign dout = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_write && !do_read) begin
                count <= count + 1'b1;
            end else if (do_read && !do_write) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* src/window_buffer.sv */
`timescale 1ns/1ps

module window_buffer #(
    parameter int IMAGE_WIDTH = 720
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               shift_en,
    input  image_pkg::pixel_t  shift_pixel,
    output image_pkg::window_t window
);

    // Four full lines plus five samples cover the whole 5x5 neighbourhood
    localparam int SR_LEN = 4 * IMAGE_WIDTH + 5;
    localparam int PIX_W  = $bits(image_pkg::pixel_t);
    localparam int TAPS   = 25;

    // Index 0 holds the oldest sample, SR_LEN-1 the newest
    image_pkg::pixel_t taps [SR_LEN];
    logic [TAPS*PIX_W-1:0] window_bits;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < SR_LEN; i++) begin
                taps[i] <= '0;
            end
        end else if (shift_en) begin
            for (int i = 0; i < SR_LEN - 1; i++) begin
                taps[i] <= taps[i + 1];
            end
            taps[SR_LEN - 1] <= shift_pixel;
        end
    end

    // Tap for window row r, column c sits r lines plus c samples after the oldest.
    // Row 0 column 0 lands in the most significant bits of the struct.
    for (genvar r = 0; r < 5; r++) begin : g_row
        for (genvar c = 0; c < 5; c++) begin : g_col
            localparam int SLOT = TAPS - 1 - (r * 5 + c);
            assign window_bits[SLOT*PIX_W +: PIX_W] = taps[r * IMAGE_WIDTH + c];
        end
    end

    assign window = image_pkg::window_t'(window_bits);

endmodule

/* src/blur_kernel.sv */
`timescale 1ns/1ps

module blur_kernel (
    input  logic               clock,
    input  logic               reset,
    input  logic               calc_en,
    input  image_pkg::window_t window,
    input  logic               border,
    output image_pkg::pixel_t  blurred
);

    localparam int PIX_W = $bits(image_pkg::pixel_t);
    localparam int TAPS  = 25;
    localparam int ACC_W = blur_pkg::ACC_WIDTH;

    logic [TAPS*PIX_W-1:0] window_bits;
    logic [ACC_W-1:0]      acc;
    logic [ACC_W-1:0]      quotient;

    assign window_bits = window;

    // Weighted sum over the neighbourhood, top-left tap in the top bits
    always_comb begin : mac_sum
        image_pkg::pixel_t px;
        acc = '0;
        for (int r = 0; r < 5; r++) begin
            for (int c = 0; c < 5; c++) begin
                px  = window_bits[(TAPS - 1 - (r * 5 + c)) * PIX_W +: PIX_W];
                acc = acc + ACC_W'(px * blur_pkg::kernel_weight(r, c));
            end
        end
    end

    // Truncating divide, result is at most 255
    assign quotient = acc / ACC_W'(blur_pkg::KERNEL_SUM);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            blurred <= '0;
        end else if (calc_en) begin
            // Neighbourhood hangs off the frame near the edges
            blurred <= border ? '0 : image_pkg::pixel_t'(quotient);
        end
    end

endmodule

/* src/gaussian_blur.sv */
`timescale 1ns/1ps

module gaussian_blur #(
    parameter int IMAGE_WIDTH  = 720,
    parameter int IMAGE_HEIGHT = 540
) (
    input  logic              clock,
    input  logic              reset,
    output logic              fifo_rd_en,
    input  logic              fifo_empty,
    input  image_pkg::pixel_t fifo_dout,
    output logic              out_wr_en,
    input  logic              out_full,
    output image_pkg::pixel_t out_din
);

    // Shifts needed before pixel (0,0) reaches the centre tap
    localparam int PROLOGUE_LEN = 2 * IMAGE_WIDTH + 3;
    localparam int PIXEL_COUNT  = IMAGE_WIDTH * IMAGE_HEIGHT;
    localparam int PRO_W        = $clog2(PROLOGUE_LEN + 1);
    localparam int CNT_W        = $clog2(PIXEL_COUNT + 1);

    blur_pkg::blur_state_t state, next_state;
    logic [PRO_W-1:0]      prologue_cnt, prologue_cnt_next;
    logic [CNT_W-1:0]      consumed, consumed_next;
    image_pkg::pixel_pos_t pos, pos_next;

    logic               pixels_left;
    logic               sample_ready;
    logic               shift_en;
    logic               calc_en;
    logic               border;
    logic               last_pos;
    image_pkg::pixel_t  shift_pixel;
    image_pkg::pixel_t  blurred;
    image_pkg::window_t window;

    assign pixels_left  = (consumed < CNT_W'(PIXEL_COUNT));
    // Zero padding never waits on the FIFO
    assign sample_ready = !pixels_left || !fifo_empty;
    assign shift_pixel  = pixels_left ? fifo_dout : '0;

    assign border = (pos.row < 16'd2) || (pos.row > 16'(IMAGE_HEIGHT - 3)) ||
                    (pos.col < 16'd2) || (pos.col > 16'(IMAGE_WIDTH - 3));
    assign last_pos = (pos.row == 16'(IMAGE_HEIGHT - 1)) && (pos.col == 16'(IMAGE_WIDTH - 1));
    assign out_din  = blurred;

    window_buffer #(.IMAGE_WIDTH(IMAGE_WIDTH)) u_window (
        .clock(clock), .reset(reset), .shift_en(shift_en),
        .shift_pixel(shift_pixel), .window(window)
    );

    blur_kernel u_kernel (
        .clock(clock), .reset(reset), .calc_en(calc_en),
        .window(window), .border(border), .blurred(blurred)
    );

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state        <= blur_pkg::LOAD;
            prologue_cnt <= '0;
            consumed     <= '0;
            pos          <= '0;
        end else begin
            state        <= next_state;
            prologue_cnt <= prologue_cnt_next;
            consumed     <= consumed_next;
            pos          <= pos_next;
        end
    end

    always_comb begin
        next_state        = state;
        prologue_cnt_next = prologue_cnt;
        consumed_next     = consumed;
        pos_next          = pos;
        fifo_rd_en        = 1'b0;
        out_wr_en         = 1'b0;
        shift_en          = 1'b0;
        calc_en           = 1'b0;
        case (state)
            blur_pkg::LOAD: begin
                if (sample_ready) begin
                    shift_en   = 1'b1;
                    fifo_rd_en = pixels_left;
                    if (pixels_left) begin
                        consumed_next = consumed + 1'b1;
                    end
                    // Prologue counter saturates once the window is primed
                    if (prologue_cnt == PRO_W'(PROLOGUE_LEN)) begin
                        next_state = blur_pkg::CALC;
                    end else begin
                        prologue_cnt_next = prologue_cnt + 1'b1;
                        if (prologue_cnt == PRO_W'(PROLOGUE_LEN - 1)) begin
                            next_state = blur_pkg::CALC;
                        end
                    end
                end
            end
            blur_pkg::CALC: begin
                calc_en    = 1'b1;
                next_state = blur_pkg::EMIT;
            end
            blur_pkg::EMIT: begin
                if (!out_full) begin
                    out_wr_en  = 1'b1;
                    next_state = blur_pkg::LOAD;
                    if (last_pos) begin
                        // Last pixel of the frame restarts the prologue for the next one
                        pos_next          = '0;
                        prologue_cnt_next = '0;
                        consumed_next     = '0;
                    end else if (pos.col == 16'(IMAGE_WIDTH - 1)) begin
                        pos_next.col = '0;
                        pos_next.row = pos.row + 1'b1;
                    end else begin
                        pos_next.col = pos.col + 1'b1;
                    end
                end
            end
            default: begin
                next_state = blur_pkg::LOAD;
            end
        endcase
    end

endmodule

/* src/blur_top.sv */
`timescale 1ns/1ps

module blur_top #(
    parameter int IMAGE_WIDTH  = 720,
    parameter int IMAGE_HEIGHT = 540,
    parameter int FIFO_DEPTH   = 16
) (
    input  logic              clock,
    input  logic              reset,
    input  logic              in_wr_en,
    input  image_pkg::pixel_t in_din,
    output logic              in_full,
    input  logic              out_rd_en,
    output image_pkg::pixel_t out_dout,
    output logic              out_empty
);

    // Input FIFO to core
    logic              in_rd_en;
    logic              in_empty;
    image_pkg::pixel_t in_dout;

    // Core to output FIFO
    logic              core_wr_en;
    logic              core_full;
    image_pkg::pixel_t core_din;

    pixel_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_in_fifo (
        .clock(clock), .reset(reset),
        .wr_en(in_wr_en), .din(in_din), .full(in_full),
        .rd_en(in_rd_en), .dout(in_dout), .empty(in_empty)
    );

    gaussian_blur #(
        .IMAGE_WIDTH(IMAGE_WIDTH),
        .IMAGE_HEIGHT(IMAGE_HEIGHT)
    ) u_blur (
        .clock(clock), .reset(reset),
        .fifo_rd_en(in_rd_en), .fifo_empty(in_empty), .fifo_dout(in_dout),
        .out_wr_en(core_wr_en), .out_full(core_full), .out_din(core_din)
    );

    pixel_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_out_fifo (
        .clock(clock), .reset(reset),
        .wr_en(core_wr_en), .din(core_din), .full(core_full),
        .rd_en(out_rd_en), .dout(out_dout), .empty(out_empty)
    );

endmodule

/* verif/blur_tb.sv */
`timescale 1ns/1ps

module blur_tb;

    localparam int IMAGE_WIDTH  = 8;
    localparam int IMAGE_HEIGHT = 6;
    localparam int FIFO_DEPTH   = 16;
    // Six frames of 48 pixels at about 8 cycles each plus holds, with a wide margin
    localparam int CYCLE_LIMIT  = 6000;
    // Longest wait for the next output before a frame counts as short
    localparam int IDLE_LIMIT   = 200;

    logic              clock;
    logic              reset;
    logic              in_wr_en;
    image_pkg::pixel_t in_din;
    logic              in_full;
    logic              out_rd_en;
    image_pkg::pixel_t out_dout;
    logic              out_empty;

    int          frame [IMAGE_HEIGHT][IMAGE_WIDTH];
    int          in_q[$];
    int          exp_q[$];
    logic [31:0] rng_state;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycles = 0;

    blur_top #(
        .IMAGE_WIDTH(IMAGE_WIDTH),
        .IMAGE_HEIGHT(IMAGE_HEIGHT),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) uut (
        .clock(clock), .reset(reset),
        .in_wr_en(in_wr_en), .in_din(in_din), .in_full(in_full),
        .out_rd_en(out_rd_en), .out_dout(out_dout), .out_empty(out_empty)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Kernel rows 2,4,5,4,2 / 4,9,12,9,4 / 5,12,15,12,5 and mirrored below
    function automatic int gauss_weight(input int r, input int c);
        case (r * 5 + c)
            0, 4, 20, 24: return 2;
            1, 3, 5, 9, 15, 19, 21, 23: return 4;
            2, 10, 14, 22: return 5;
            6, 8, 16, 18: return 9;
            7, 11, 13, 17: return 12;
            default: return 15;
        endcase
    endfunction

    task automatic fill_frame(input int value);
        for (int r = 0; r < IMAGE_HEIGHT; r++) begin
            for (int c = 0; c < IMAGE_WIDTH; c++) begin
                frame[r][c] = value;
            end
        end
    endtask

    task automatic fill_random_frame();
        for (int r = 0; r < IMAGE_HEIGHT; r++) begin
            for (int c = 0; c < IMAGE_WIDTH; c++) begin
                frame[r][c] = int'(next_random() & 32'hff);
            end
        end
    endtask

    // Queue the frame for sending and its blurred result for checking
    task automatic queue_frame();
        int acc;
        for (int r = 0; r < IMAGE_HEIGHT; r++) begin
            for (int c = 0; c < IMAGE_WIDTH; c++) begin
                in_q.push_back(frame[r][c]);
                if (r < 2 || r > IMAGE_HEIGHT - 3 || c < 2 || c > IMAGE_WIDTH - 3) begin
                    exp_q.push_back(0);
                end else begin
                    acc = 0;
                    for (int i = 0; i < 5; i++) begin
                        for (int j = 0; j < 5; j++) begin
                            acc += frame[r - 2 + i][c - 2 + j] * gauss_weight(i, j);
                        end
                    end
                    exp_q.push_back(acc / 159);
                end
            end
        end
    endtask

    // Pushes queued pixels and pops outputs each cycle
    // Pops wait for in_full when hold is set
    task automatic stream_frames(input bit hold_output);
        int idle;
        int got;
        bit draining;
        idle = 0;
        draining = !hold_output;
        while (exp_q.size() > 0 && idle < IDLE_LIMIT) begin
            @(posedge clock);
            #1;
            if (in_q.size() > 0 && !in_full) begin
                in_wr_en = 1'b1;
                in_din = 8'(in_q.pop_front());
            end else begin
                in_wr_en = 1'b0;
            end
            if (in_full) begin
                draining = 1'b1;
            end
            if (draining && !out_empty) begin
                out_rd_en = 1'b1;
                got = int'(out_dout);
                assert (got == exp_q[0]) else begin
                    $display("Fail at %0t: out_dout = %0d, expected %0d", $time, got, exp_q[0]);
                    errors++;
                end
                void'(exp_q.pop_front());
                idle = 0;
            end else begin
                out_rd_en = 1'b0;
                idle++;
            end
        end
        @(posedge clock);
        #1;
        in_wr_en  = 1'b0;
        out_rd_en = 1'b0;
        assert (exp_q.size() == 0) else begin
            $display("Frame stopped with %0d outputs still missing", exp_q.size());
            errors++;
        end
        exp_q.delete();
        in_q.delete();
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors > errors_before) begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - errors_before);
        end else begin
            $display("%s: passed", name);
        end
    endtask

    task automatic check_reset_state();
        int start;
        start = errors;
        assert (out_empty === 1'b1) else begin
            $display("Fail at %0t: out_empty = %b, expected 1", $time, out_empty);
            errors++;
        end
        assert (in_full === 1'b0) else begin
            $display("Fail at %0t: in_full = %b, expected 0", $time, in_full);
            errors++;
        end
        finish_test("reset_state", start);
    endtask

    task automatic flat_frame();
        int start;
        start = errors;
        fill_frame(100);
        queue_frame();
        stream_frames(1'b0);
        finish_test("flat_frame", start);
    endtask

    task automatic impulse_response();
        int start;
        start = errors;
        fill_frame(0);
        frame[3][4] = 255;
        queue_frame();
        stream_frames(1'b0);
        finish_test("impulse", start);
    endtask

    task automatic random_frame();
        int start;
        start = errors;
        fill_random_frame();
        queue_frame();
        stream_frames(1'b0);
        finish_test("random_frame", start);
    endtask

    task automatic output_back_pressure();
        int start;
        start = errors;
        fill_random_frame();
        queue_frame();
        stream_frames(1'b1);
        finish_test("back_pressure", start);
    endtask

    // Second frame follows without reset, so the flush and restart are exercised
    task automatic back_to_back_frames();
        int start;
        start = errors;
        fill_random_frame();
        queue_frame();
        fill_random_frame();
        queue_frame();
        stream_frames(1'b0);
        finish_test("back_to_back", start);
    endtask

    initial begin
        reset     = 1'b1;
        in_wr_en  = 1'b0;
        in_din    = '0;
        out_rd_en = 1'b0;
        rng_state = 32'h7186_aba6;
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;
        check_reset_state();
        flat_frame();
        impulse_response();
        random_frame();
        output_back_pressure();
        back_to_back_frames();
        $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* tb.f */
src/image_pkg.sv
src/blur_pkg.sv
src/pixel_fifo.sv
src/window_buffer.sv
src/blur_kernel.sv
src/gaussian_blur.sv
src/blur_top.sv
verif/blur_tb.sv
